// File: include/icache_defines.svh
// ==============================
// icache build constants
// ==============================

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// width of a fetch address and of an AXI read address
`define ICACHE_ADDR_W 32

// bytes in one cache line, the offset takes address bits 3:0
`define ICACHE_LINE_BYTES 16

// number of direct-mapped sets, the index takes address bits 9:4
`define ICACHE_SETS 64

// 32-bit words read from memory to fill one line
`define ICACHE_FILL_BEATS 4

// reads that may be issued on AR and not yet returned on R
`define ICACHE_MAX_OUTSTANDING 2

// cycle limit for any single wait in the testbench
`define ICACHE_FETCH_TIMEOUT 400

`endif

// File: source/icache_pkg.sv
// ==============================
// icache types
// ==============================

`include "icache_defines.svh"

package icache_pkg;

	localparam int ADDR_W = `ICACHE_ADDR_W;
	localparam int OFFSET_W = $clog2(`ICACHE_LINE_BYTES);
	localparam int INDEX_W = $clog2(`ICACHE_SETS);
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
	// one memory word is the unit of a fill beat
	localparam int WORD_W = `ICACHE_LINE_BYTES * 8 / `ICACHE_FILL_BEATS;
	// pc plus this step addresses the second line that a fetch may touch
	localparam logic [ADDR_W-1:0] FETCH_STEP = 8;

	typedef logic [INDEX_W-1:0] set_index_t;

	// the tag field holds address bits 31:10 and valid sits in bit 0
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic             valid;
	} tag_entry_t;

	typedef logic [`ICACHE_LINE_BYTES*8-1:0] line_t;

	// eight instruction bytes with the byte at pc in bits 7:0
	typedef logic [2*WORD_W-1:0] fetch_window_t;

endpackage

// File: source/axi_lite_pkg.sv
// ==============================
// AXI4-Lite read types
// ==============================

package axi_lite_pkg;

	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;

	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;

	// rresp encoding, exclusive access is not part of AXI4-Lite
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t resp_okay = 2'b00;
	localparam axi_resp_t resp_slverr = 2'b10;
	localparam axi_resp_t resp_decerr = 2'b11;

endpackage

// File: source/sync_ram_1w1r.sv
// ==============================
// one write one read RAM
// ==============================

`timescale 1ns/100ps
`include "icache_defines.svh"

module sync_ram_1w1r #(
	parameter type entry_t = icache_pkg::line_t
) (
	input  logic                   rclk,
	input  logic                   we,
	input  icache_pkg::set_index_t wadr,
	input  entry_t                 wdata,
	input  icache_pkg::set_index_t radr,
	output entry_t                 rdata
);
	import icache_pkg::*;

	entry_t     mem [`ICACHE_SETS];
	set_index_t radr_q;

	// the read address is registered, the array is read behind it
	// so a write at the same edge shows up in the next cycle
	always_ff @(posedge rclk) begin
		if (we)
			mem[wadr] <= wdata;
		radr_q <= radr;
	end

	assign rdata = mem[radr_q];

endmodule

// File: source/icache_tag_mem.sv
// ==============================
// icache tag store
// ==============================

`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_tag_mem (
	input  logic                      rclk,
	input  logic                      we,
	input  icache_pkg::set_index_t    wadr,
	input  icache_pkg::tag_entry_t    wentry,
	input  logic [`ICACHE_ADDR_W-1:0] pc,
	output logic                      hit0,
	output logic                      hit1
);
	import icache_pkg::*;

	logic [ADDR_W-1:0] pcp8;
	logic [ADDR_W-1:0] rpc;
	logic [ADDR_W-1:0] rpcp8;
	tag_entry_t        tag0;
	tag_entry_t        tag1;

	// the fetch window may run into the next line
	assign pcp8 = pc + FETCH_STEP;

	// both addresses are kept for the compare in the cycle after lookup
	always_ff @(posedge rclk) begin
		rpc <= pc;
		rpcp8 <= pcp8;
	end

	// ==============================
	// tag RAMs
	// ==============================

	// both copies get the same writes, only the read index differs
	sync_ram_1w1r #(.entry_t(tag_entry_t)) tag_ram0 (
		.rclk  (rclk),
		.we    (we),
		.wadr  (wadr),
		.wdata (wentry),
		.radr  (pc[OFFSET_W +: INDEX_W]),
		.rdata (tag0)
	);

	sync_ram_1w1r #(.entry_t(tag_entry_t)) tag_ram1 (
		.rclk  (rclk),
		.we    (we),
		.wadr  (wadr),
		.wdata (wentry),
		.radr  (pcp8[OFFSET_W +: INDEX_W]),
		.rdata (tag1)
	);

	// a stored tag only counts when its valid bit is set
	assign hit0 = tag0.valid && (tag0.tag == rpc[OFFSET_W+INDEX_W +: TAG_W]);
	assign hit1 = tag1.valid && (tag1.tag == rpcp8[OFFSET_W+INDEX_W +: TAG_W]);

endmodule

// File: source/icache_data_path.sv
// ==============================
// icache data lines
// ==============================

`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_data_path (
	input  logic                                 rclk,
	input  logic                                 rst,
	input  logic [`ICACHE_ADDR_W-1:0]            pc,
	input  logic                                 beat_valid,
	input  logic [$clog2(`ICACHE_FILL_BEATS)-1:0] beat_index,
	input  logic [icache_pkg::WORD_W-1:0]        rdata,
	input  logic                                 line_we,
	input  icache_pkg::set_index_t               line_wadr,
	output icache_pkg::fetch_window_t            window
);
	import icache_pkg::*;

	logic [ADDR_W-1:0] pcp8;
	line_t             fill_buf;
	line_t             fill_line;
	line_t             line0;
	line_t             line1;
	logic [1:0]        off_q;

	assign pcp8 = pc + FETCH_STEP;

	// returned words collect here in address order during a fill
	always_ff @(posedge rclk) begin
		if (beat_valid)
			fill_buf[beat_index*WORD_W +: WORD_W] <= rdata;
	end

	// the last word is merged in directly so the line is written with its final beat
	always_comb begin
		fill_line = fill_buf;
		if (beat_valid)
			fill_line[beat_index*WORD_W +: WORD_W] = rdata;
	end

	sync_ram_1w1r #(.entry_t(line_t)) data_ram0 (
		.rclk  (rclk),
		.we    (line_we),
		.wadr  (line_wadr),
		.wdata (fill_line),
		.radr  (pc[OFFSET_W +: INDEX_W]),
		.rdata (line0)
	);

	sync_ram_1w1r #(.entry_t(line_t)) data_ram1 (
		.rclk  (rclk),
		.we    (line_we),
		.wadr  (line_wadr),
		.wdata (fill_line),
		.radr  (pcp8[OFFSET_W +: INDEX_W]),
		.rdata (line1)
	);

	// word offset lines up with the RAM outputs one cycle later
	always_ff @(posedge rclk) begin
		if (rst)
			off_q <= '0;
		else
			off_q <= pc[OFFSET_W-1 -: 2];
	end

	// only offset 3 takes its upper word from the next line
	always_comb begin
		case (off_q)
			2'd0: window = line0[63:0];
			2'd1: window = line0[95:32];
			2'd2: window = line0[127:64];
			default: window = {line1[31:0], line0[127:96]};
		endcase
	end

endmodule

// File: source/icache_fill_fsm.sv
// ==============================
// icache fill control
// ==============================

`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_fill_fsm (
	input  logic                      rclk,
	input  logic                      rst,
	input  logic                      fetch_req,
	input  logic [`ICACHE_ADDR_W-1:0] fetch_pc,
	input  logic                      hit0,
	input  logic                      hit1,
	input  axi_lite_pkg::axi_resp_t   rresp,
	input  logic                      beat_valid,
	input  logic                      fill_done,
	output logic                      fetch_ready,
	output logic                      fetch_valid,
	output logic                      fetch_err,
	output logic [`ICACHE_ADDR_W-1:0] lookup_pc,
	output logic                      start,
	output axi_lite_pkg::axi_addr_t   line_base,
	output logic                      tag_we,
	output icache_pkg::set_index_t    tag_wadr,
	output icache_pkg::tag_entry_t    tag_wentry,
	output logic                      line_we
);
	import icache_pkg::*;
	import axi_lite_pkg::*;

	typedef enum logic [2:0] {
		st_sweep,
		st_idle,
		st_lookup,
		st_fill0,
		st_fill1,
		st_respond
	} state_t;

	state_t            state;
	state_t            state_nx;
	logic [ADDR_W-1:0] req_pc;
	logic [ADDR_W-1:0] next_pc;
	set_index_t        sweep_idx;
	logic              err_q;
	logic              miss1_q;
	logic              need1;
	logic              all_hit;
	logic              accept;
	logic              line_err;

	assign next_pc = req_pc + FETCH_STEP;
	// the next line counts as needed from word offset 2 on
	assign need1 = req_pc[OFFSET_W-1];
	assign all_hit = hit0 && (hit1 || !need1);
	assign accept = fetch_req && fetch_ready;
	// a bad response on any beat of the current fetch poisons the line
	assign line_err = err_q || (beat_valid && (rresp != resp_okay));

	// ==============================
	// next state and outputs
	// ==============================

	always_comb begin
		state_nx = state;
		fetch_ready = 1'b0;
		fetch_valid = 1'b0;
		fetch_err = 1'b0;
		// while a miss is handled the RAMs keep reading the missed fetch
		lookup_pc = req_pc;
		start = 1'b0;
		line_base = {req_pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
		tag_we = 1'b0;
		line_we = 1'b0;
		tag_wadr = req_pc[OFFSET_W +: INDEX_W];
		tag_wentry.tag = req_pc[OFFSET_W+INDEX_W +: TAG_W];
		tag_wentry.valid = !line_err;
		case (state)
			st_sweep: begin
				// one set is cleared per cycle
				tag_we = 1'b1;
				tag_wadr = sweep_idx;
				tag_wentry = '0;
				if (sweep_idx == set_index_t'(`ICACHE_SETS-1))
					state_nx = st_idle;
			end
			st_idle: begin
				fetch_ready = 1'b1;
				lookup_pc = fetch_pc;
				if (fetch_req)
					state_nx = st_lookup;
			end
			st_lookup: begin
				if (all_hit) begin
					// a hit completes now and the port takes the next fetch
					fetch_valid = 1'b1;
					fetch_ready = 1'b1;
					lookup_pc = fetch_pc;
					state_nx = fetch_req ? st_lookup : st_idle;
				end else begin
					start = 1'b1;
					if (hit0) begin
						line_base = {next_pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
						state_nx = st_fill1;
					end else begin
						state_nx = st_fill0;
					end
				end
			end
			st_fill0: begin
				if (fill_done) begin
					tag_we = 1'b1;
					line_we = 1'b1;
					// after a failed line the second fill is skipped
					if (!line_err && miss1_q) begin
						start = 1'b1;
						line_base = {next_pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
						state_nx = st_fill1;
					end else begin
						state_nx = st_respond;
					end
				end
			end
			st_fill1: begin
				tag_wadr = next_pc[OFFSET_W +: INDEX_W];
				tag_wentry.tag = next_pc[OFFSET_W+INDEX_W +: TAG_W];
				if (fill_done) begin
					tag_we = 1'b1;
					line_we = 1'b1;
					state_nx = st_respond;
				end
			end
			st_respond: begin
				// the final lookup of the missed fetch now reads the filled lines
				fetch_valid = 1'b1;
				fetch_err = err_q;
				fetch_ready = 1'b1;
				lookup_pc = fetch_pc;
				state_nx = fetch_req ? st_lookup : st_idle;
			end
			default: state_nx = st_idle;
		endcase
	end

	// ==============================
	// state registers
	// ==============================

	always_ff @(posedge rclk) begin
		if (rst) begin
			state <= st_sweep;
			sweep_idx <= '0;
			err_q <= 1'b0;
			miss1_q <= 1'b0;
		end else begin
			state <= state_nx;
			if (state == st_sweep)
				sweep_idx <= sweep_idx + 1'b1;
			if (accept)
				err_q <= 1'b0;
			else if (beat_valid && (rresp != resp_okay))
				err_q <= 1'b1;
			if ((state == st_lookup) && !all_hit)
				miss1_q <= need1 && !hit1;
		end
	end

	// the accepted pc is kept for the fill and the final lookup
	always_ff @(posedge rclk) begin
		if (accept)
			req_pc <= fetch_pc;
	end

endmodule

// File: source/fill_beat_counter.sv
// ==============================
// AXI read beat counter
// ==============================

`timescale 1ns/100ps
`include "icache_defines.svh"

module fill_beat_counter (
	input  logic                                  rclk,
	input  logic                                  rst,
	input  logic                                  start,
	input  axi_lite_pkg::axi_addr_t               line_base,
	input  logic                                  arready,
	input  logic                                  rvalid,
	output logic                                  arvalid,
	output axi_lite_pkg::axi_addr_t               araddr,
	output logic                                  rready,
	output logic                                  beat_valid,
	output logic [$clog2(`ICACHE_FILL_BEATS)-1:0] beat_index,
	output logic                                  fill_done
);
	import axi_lite_pkg::*;

	localparam int CNT_W = $clog2(`ICACHE_FILL_BEATS + 1);
	localparam int BEAT_W = $clog2(`ICACHE_FILL_BEATS);
	localparam logic [CNT_W-1:0] BEATS = `ICACHE_FILL_BEATS;
	localparam logic [CNT_W-1:0] MAX_PEND = `ICACHE_MAX_OUTSTANDING;

	logic             active;
	logic [CNT_W-1:0] issued;
	logic [CNT_W-1:0] returned;
	logic [CNT_W-1:0] pending;
	axi_addr_t        base_q;

	// reads on AR that have not come back on R yet
	assign pending = issued - returned;

	// pending only drops while arvalid waits, so arvalid holds until arready
	assign arvalid = active && (issued < BEATS) && (pending < MAX_PEND);
	// words are requested in ascending order, 4 bytes apart
	assign araddr = base_q + axi_addr_t'({issued[BEAT_W-1:0], 2'b00});

	assign rready = active && (pending != '0);
	assign beat_valid = rvalid && rready;
	assign beat_index = returned[BEAT_W-1:0];
	assign fill_done = beat_valid && (returned == BEATS - 1'b1);

	always_ff @(posedge rclk) begin
		if (rst) begin
			active <= 1'b0;
			issued <= '0;
			returned <= '0;
		end else if (start) begin
			// a new line may start on the edge that ends the previous one
			active <= 1'b1;
			issued <= '0;
			returned <= '0;
		end else begin
			if (arvalid && arready)
				issued <= issued + 1'b1;
			if (beat_valid)
				returned <= returned + 1'b1;
			if (fill_done)
				active <= 1'b0;
		end
	end

	always_ff @(posedge rclk) begin
		if (start)
			base_q <= line_base;
	end

endmodule

// File: source/icache_top.sv
// ==============================
// icache front end
// ==============================

`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_top (
	input  logic                      rclk,
	input  logic                      rst,
	// fetch port
	input  logic                      fetch_req,
	input  logic [`ICACHE_ADDR_W-1:0] fetch_pc,
	output logic                      fetch_ready,
	output logic                      fetch_valid,
	output icache_pkg::fetch_window_t fetch_data,
	output logic                      fetch_err,
	// AXI4-Lite read master
	output axi_lite_pkg::axi_addr_t   araddr,
	output logic                      arvalid,
	input  logic                      arready,
	input  axi_lite_pkg::axi_data_t   rdata,
	input  axi_lite_pkg::axi_resp_t   rresp,
	input  logic                      rvalid,
	output logic                      rready
);
	import icache_pkg::*;
	import axi_lite_pkg::*;

	logic [ADDR_W-1:0] lookup_pc;
	logic              hit0;
	logic              hit1;
	logic              tag_we;
	set_index_t        tag_wadr;
	tag_entry_t        tag_wentry;
	logic              line_we;
	logic              start;
	axi_addr_t         line_base;
	logic              beat_valid;
	logic [$clog2(`ICACHE_FILL_BEATS)-1:0] beat_index;
	logic              fill_done;

	icache_tag_mem tag_mem0 (
		.rclk   (rclk),
		.we     (tag_we),
		.wadr   (tag_wadr),
		.wentry (tag_wentry),
		.pc     (lookup_pc),
		.hit0   (hit0),
		.hit1   (hit1)
	);

	// the data lines are written with the same index as the tags
	icache_data_path data_path0 (
		.rclk       (rclk),
		.rst        (rst),
		.pc         (lookup_pc),
		.beat_valid (beat_valid),
		.beat_index (beat_index),
		.rdata      (rdata),
		.line_we    (line_we),
		.line_wadr  (tag_wadr),
		.window     (fetch_data)
	);

	icache_fill_fsm fill_fsm0 (
		.rclk        (rclk),
		.rst         (rst),
		.fetch_req   (fetch_req),
		.fetch_pc    (fetch_pc),
		.hit0        (hit0),
		.hit1        (hit1),
		.rresp       (rresp),
		.beat_valid  (beat_valid),
		.fill_done   (fill_done),
		.fetch_ready (fetch_ready),
		.fetch_valid (fetch_valid),
		.fetch_err   (fetch_err),
		.lookup_pc   (lookup_pc),
		.start       (start),
		.line_base   (line_base),
		.tag_we      (tag_we),
		.tag_wadr    (tag_wadr),
		.tag_wentry  (tag_wentry),
		.line_we     (line_we)
	);

	fill_beat_counter beat_counter0 (
		.rclk       (rclk),
		.rst        (rst),
		.start      (start),
		.line_base  (line_base),
		.arready    (arready),
		.rvalid     (rvalid),
		.arvalid    (arvalid),
		.araddr     (araddr),
		.rready     (rready),
		.beat_valid (beat_valid),
		.beat_index (beat_index),
		.fill_done  (fill_done)
	);

endmodule

// File: verif/icache_tb.sv
// ==============================
// icache testbench
// ==============================

`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_tb;
	import icache_pkg::*;
	import axi_lite_pkg::*;

	localparam int MAX_TESTS = 32;
	localparam logic [31:0] MEM_XOR = 32'h5a5a0000;

	logic                      rclk = 1'b0;
	logic                      rst = 1'b1;
	logic                      fetch_req = 1'b0;
	logic [`ICACHE_ADDR_W-1:0] fetch_pc = '0;
	logic                      fetch_ready;
	logic                      fetch_valid;
	fetch_window_t             fetch_data;
	logic                      fetch_err;
	axi_addr_t                 araddr;
	logic                      arvalid;
	logic                      arready = 1'b0;
	axi_data_t                 rdata = '0;
	axi_resp_t                 rresp = resp_okay;
	logic                      rvalid = 1'b0;
	logic                      rready;

	// each trace entry takes four words for pc, window, AR count and error flag
	logic [63:0]   trace_mem [0:4*MAX_TESTS-1];
	int            n_tests;
	int            ar_count = 0;
	int            ar_base;
	int            ar_delay = 0;
	int            r_delay = 0;
	logic [31:0]   rng = 32'hca1454f9;
	axi_addr_t     rd_queue [$];
	axi_addr_t     mem_addr;

	icache_top dut0 (
		.rclk (rclk), .rst (rst),
		.fetch_req (fetch_req), .fetch_pc (fetch_pc), .fetch_ready (fetch_ready),
		.fetch_valid (fetch_valid), .fetch_data (fetch_data), .fetch_err (fetch_err),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
	);

	always #50 rclk = ~rclk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// a line faults when any trace entry in that line expects fetch_err
	function automatic logic line_faults(input axi_addr_t addr);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < n_tests; i++)
			if (trace_mem[4*i+3][0] && (trace_mem[4*i][31:4] == addr[31:4]))
				hit = 1'b1;
		return hit;
	endfunction

	// ==============================
	// AXI4-Lite memory model
	// ==============================

	// R is served before AR so every queued address already finished its AR handshake
	always @(negedge rclk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			rvalid <= 1'b0;
			if ((rd_queue.size() > 0) && rready) begin
				if (r_delay == 0) begin
					mem_addr = rd_queue.pop_front();
					rvalid <= 1'b1;
					rdata <= mem_addr ^ MEM_XOR;
					rresp <= line_faults(mem_addr) ? resp_slverr : resp_okay;
					rng = xorshift32(rng);
					r_delay = rng[1:0];
				end else begin
					r_delay = r_delay - 1;
				end
			end
			// arvalid only moves at a rising edge so a grant here always completes
			arready <= 1'b0;
			if (arvalid) begin
				if (ar_delay == 0) begin
					arready <= 1'b1;
					rd_queue.push_back(araddr);
					ar_count <= ar_count + 1;
					rng = xorshift32(rng);
					ar_delay = rng[3:2];
				end else begin
					ar_delay = ar_delay - 1;
				end
			end
		end
	end

	// present one trace entry for acceptance at the next rising edge
	task automatic drive_fetch(input int k);
		fetch_req <= 1'b1;
		fetch_pc <= trace_mem[4*k][31:0];
		ar_base = ar_count;
	endtask

	// ==============================
	// trace replay and checks
	// ==============================

	initial begin
		int  idx;
		int  cycles;
		int  pass_count;
		int  fail_count;
		int  ar_seen;
		logic done;
		logic test_ok;
		logic timed_out;
		pass_count = 0;
		fail_count = 0;
		timed_out = 1'b0;
		for (int i = 0; i < 4*MAX_TESTS; i++)
			trace_mem[i] = '1;
		$readmemh("verif/icache_trace.txt", trace_mem);
		n_tests = 0;
		while ((n_tests < MAX_TESTS) && (trace_mem[4*n_tests] != '1))
			n_tests++;

		repeat (3) @(negedge rclk);
		rst <= 1'b0;

		// the invalidation sweep has to finish before the port opens
		cycles = 0;
		while (!fetch_ready && (cycles <= `ICACHE_SETS + 8)) begin
			@(negedge rclk);
			cycles++;
		end
		if (!fetch_ready) begin
			$display("fetch_ready did not rise after the reset sweep");
			timed_out = 1'b1;
		end else if (cycles < `ICACHE_SETS) begin
			$display("fetch_ready rose after %0d cycles before the %0d set sweep ended",
				cycles, `ICACHE_SETS);
			fail_count++;
		end

		idx = 0;
		if (!timed_out && (n_tests > 0))
			drive_fetch(0);
		while (!timed_out && (idx < n_tests)) begin
			cycles = 0;
			done = 1'b0;
			test_ok = 1'b1;
			while (!done && !timed_out) begin
				@(negedge rclk);
				cycles++;
				if (fetch_valid) begin
					done = 1'b1;
				end else begin
					if (fetch_ready) begin
						$display("fetch_ready was high while the fetch at pc %h was pending",
							trace_mem[4*idx][31:0]);
						test_ok = 1'b0;
					end
					if (cycles >= `ICACHE_FETCH_TIMEOUT) begin
						$display("test %0d pc %h timed out waiting for fetch_valid",
							idx, trace_mem[4*idx][31:0]);
						timed_out = 1'b1;
						fail_count++;
					end
				end
			end
			if (done) begin
				ar_seen = ar_count - ar_base;
				if (fetch_data !== trace_mem[4*idx+1]) begin
					$display("** Error: fetch_data pc %h got %h expected %h",
						trace_mem[4*idx][31:0], fetch_data, trace_mem[4*idx+1]);
					test_ok = 1'b0;
				end
				if (fetch_err !== trace_mem[4*idx+3][0]) begin
					$display("** Error: fetch_err pc %h got %h expected %h",
						trace_mem[4*idx][31:0], fetch_err, trace_mem[4*idx+3][0]);
					test_ok = 1'b0;
				end
				if (ar_seen != trace_mem[4*idx+2]) begin
					$display("** Error: arvalid/arready handshakes pc %h got %h expected %h",
						trace_mem[4*idx][31:0], ar_seen, trace_mem[4*idx+2][31:0]);
					test_ok = 1'b0;
				end
				// the port reopens in the same cycle that carries the result
				if (!fetch_ready) begin
					$display("fetch_ready was low when the fetch at pc %h completed",
						trace_mem[4*idx][31:0]);
					test_ok = 1'b0;
				end
				// a hit answers in the cycle right after acceptance
				if ((trace_mem[4*idx+2] == 0) && (cycles != 1)) begin
					$display("hit at pc %h took %0d cycles instead of 1",
						trace_mem[4*idx][31:0], cycles);
					test_ok = 1'b0;
				end
				if (test_ok) begin
					pass_count++;
					$display("test %0d pc %h passed", idx, trace_mem[4*idx][31:0]);
				end else begin
					fail_count++;
					$display("test %0d pc %h failed", idx, trace_mem[4*idx][31:0]);
				end
				// the next fetch goes out in the completion cycle so hits run back to back
				idx++;
				if (idx < n_tests)
					drive_fetch(idx);
				else
					fetch_req <= 1'b0;
			end
		end

		$display("%0d tests, %0d passed, %0d failed", n_tests, pass_count, fail_count);
		if ((fail_count == 0) && !timed_out && (n_tests > 0))
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: verif/icache_trace.txt
// columns: pc, window {word at pc+4, word at pc}, AR handshakes, fetch_err
// each memory word is its address xor 5a5a0000, lines of fetch_err entries fault
00001000 5a5a10045a5a1000 4 0
00001004 5a5a10085a5a1004 0 0
0000201c 5a5a20205a5a201c 8 0
00003048 5a5a304c5a5a3048 8 0
00002024 5a5a20285a5a2024 0 0
0000305c 5a5a30605a5a305c 4 0
00001400 5a5a14045a5a1400 4 0
00001004 5a5a10085a5a1004 4 0
00001400 5a5a14045a5a1400 4 0
00004080 5a5a40845a5a4080 4 1
00004084 5a5a40885a5a4084 4 1
00002014 5a5a20185a5a2014 0 0
00003044 5a5a30485a5a3044 0 0
0000304c 5a5a30505a5a304c 0 0
00003060 5a5a30645a5a3060 0 0
00001404 5a5a14085a5a1404 0 0
00002028 5a5a202c5a5a2028 4 0

// File: src.f
+incdir+include
source/icache_pkg.sv
source/axi_lite_pkg.sv
source/sync_ram_1w1r.sv
source/icache_tag_mem.sv
source/icache_data_path.sv
source/icache_fill_fsm.sv
source/fill_beat_counter.sv
source/icache_top.sv
verif/icache_tb.sv
